/* logic/lu_pkg.sv */
package lu_pkg;

	// ====================
	// widths
	// ====================
	localparam int n_width = 12; // matrix size and tile coordinates.
	localparam int addr_width = 24; // external memory address.
	localparam int ram_width = 8; // scratch bank address.

	// ====================
	// enums
	// ====================
	typedef enum logic [1:0]
	{
		mode_diag, // factorize the diagonal tile.
		mode_col, // solve below the diagonal.
		mode_row, // solve right of the diagonal.
		mode_update // inner tile minus left times top.
	} comp_mode_e;

	typedef enum logic [2:0]
	{
		idle,
		issue,
		wait_room,
		drain,
		done_st
	} sched_state_e;

	typedef enum logic [2:0]
	{
		x_idle,
		x_req,
		x_wait_ack,
		x_wait_done,
		x_next
	} xfer_state_e;

	// one compute step as handed from the scheduler to the transfer side.
	typedef struct packed
	{
		comp_mode_e mode;
		logic [n_width-1:0] tile_row;
		logic [n_width-1:0] tile_col;
		logic [ram_width-1:0] size_m; // clamped on the last tile row.
		logic [ram_width-1:0] size_n; // clamped on the last tile column.
		logic last;
	} step_t;

endpackage

/* logic/step_if.sv */
`timescale 1ns/1ps

interface step_if;

	lu_pkg::step_t step;
	logic push; // step handed over for its operand reads.
	logic retire; // compute of the oldest step finished.
	logic loaded; // reads of the newest step are complete.
	logic room; // fewer than two unwritten steps held.
	logic empty; // every pushed step has been written back.

	modport sched
	(
		output step,
		output push,
		output retire,
		input loaded,
		input room,
		input empty
	);

	modport xfer
	(
		input step,
		input push,
		input retire,
		output loaded,
		output room,
		output empty
	);

endinterface

/* logic/block_sched.sv */
`timescale 1ns/1ps

module block_sched #(
	parameter int BLOCK = 8,
	parameter int MAX_N = 64
) (
	input logic clk,
	input logic arst_n,
	input logic start,
	input logic [lu_pkg::n_width-1:0] n_size,
	output logic done,
	output logic comp_start,
	output lu_pkg::comp_mode_e mode,
	output logic [lu_pkg::ram_width-1:0] block_m,
	output logic [lu_pkg::ram_width-1:0] block_n,
	output logic cur_mem_sel,
	output logic left_mem_sel,
	input logic comp_done,
	step_if.sched sif
);

	localparam int nw = lu_pkg::n_width;
	localparam int rw = lu_pkg::ram_width;

	lu_pkg::sched_state_e state;
	lu_pkg::comp_mode_e lmode;
	logic [nw-1:0] k;
	logic [nw-1:0] i;
	logic [nw-1:0] j;
	logic [nw-1:0] tiles;
	logic [rw-1:0] last_sz;
	logic [nw-1:0] row;
	logic [nw-1:0] col;
	lu_pkg::step_t nxt;
	lu_pkg::step_t pend;
	lu_pkg::step_t run;
	logic [2*nw-1:0] nxt_lkey;
	logic [2*nw-1:0] pend_lkey;
	logic [2*nw-1:0] prev_lkey;
	logic prev_lv;
	logic busy;
	logic start_q;
	logic go;
	logic bad_n;

	// ====================
	// next step from the loop nest
	// ====================
	always_comb
	begin
		case (lmode)
			lu_pkg::mode_col:
			begin
				row = i;
				col = k;
			end
			lu_pkg::mode_row:
			begin
				row = k;
				col = j;
			end
			lu_pkg::mode_update:
			begin
				row = i;
				col = j;
			end
			default:
			begin
				row = k;
				col = k;
			end
		endcase
		nxt.mode = lmode;
		nxt.tile_row = row;
		nxt.tile_col = col;
		nxt.size_m = (row == tiles - 1'b1) ? last_sz : rw'(BLOCK);
		nxt.size_n = (col == tiles - 1'b1) ? last_sz : rw'(BLOCK);
		nxt.last = (lmode == lu_pkg::mode_diag) && (k == tiles - 1'b1);
		// left tile is (k, k) for col and row steps, (i, k) for updates.
		nxt_lkey = {(lmode == lu_pkg::mode_update) ? i : k, k};
	end

	assign bad_n = (n_size == '0) || (n_size > nw'(MAX_N));
	assign go = (state == lu_pkg::issue) && sif.loaded && !busy;

	assign sif.step = nxt;
	assign sif.push = (state == lu_pkg::wait_room) && sif.room;
	assign sif.retire = comp_done && busy;

	assign done = (state == lu_pkg::done_st) || ((state == lu_pkg::drain) && sif.empty);
	assign comp_start = start_q;
	assign mode = run.mode;
	assign block_m = run.size_m;
	assign block_n = run.size_n;

	// ====================
	// control
	// ====================
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= lu_pkg::idle;
			lmode <= lu_pkg::mode_diag;
			k <= '0;
			i <= '0;
			j <= '0;
			busy <= 1'b0;
			start_q <= 1'b0;
			cur_mem_sel <= 1'b0;
			left_mem_sel <= 1'b0;
			prev_lv <= 1'b0;
		end
		else
		begin
			start_q <= go;
			if (go)
			begin
				busy <= 1'b1;
				cur_mem_sel <= ~cur_mem_sel; // ping-pong on every compute.
				if (pend.mode != lu_pkg::mode_diag)
				begin
					if (!prev_lv || (pend_lkey != prev_lkey))
						left_mem_sel <= ~left_mem_sel;
					prev_lv <= 1'b1;
				end
			end
			else if (comp_done)
				busy <= 1'b0;

			case (state)
				lu_pkg::idle, lu_pkg::done_st:
				begin
					if (start)
					begin
						lmode <= lu_pkg::mode_diag;
						k <= '0;
						i <= '0;
						j <= '0;
						prev_lv <= 1'b0;
						state <= bad_n ? lu_pkg::done_st : lu_pkg::wait_room;
					end
				end
				lu_pkg::wait_room:
				begin
					if (sif.room)
					begin
						state <= lu_pkg::issue;
						case (lmode)
							lu_pkg::mode_diag:
							begin
								if (k + 1'b1 < tiles)
								begin
									lmode <= lu_pkg::mode_col;
									i <= k + 1'b1;
								end
							end
							lu_pkg::mode_col:
							begin
								if (i + 1'b1 < tiles)
									i <= i + 1'b1;
								else
								begin
									lmode <= lu_pkg::mode_row;
									j <= k + 1'b1;
								end
							end
							lu_pkg::mode_row:
							begin
								lmode <= lu_pkg::mode_update;
								i <= k + 1'b1;
							end
							default:
							begin
								if (i + 1'b1 < tiles)
									i <= i + 1'b1;
								else if (j + 1'b1 < tiles)
								begin
									lmode <= lu_pkg::mode_row;
									j <= j + 1'b1;
								end
								else
								begin
									lmode <= lu_pkg::mode_diag;
									k <= k + 1'b1;
								end
							end
						endcase
					end
				end
				lu_pkg::issue:
				begin
					if (go)
						state <= pend.last ? lu_pkg::drain : lu_pkg::wait_room;
				end
				lu_pkg::drain:
				begin
					if (sif.empty) // final write is back.
						state <= lu_pkg::done_st;
				end
				default:
					state <= lu_pkg::idle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (((state == lu_pkg::idle) || (state == lu_pkg::done_st)) && start)
		begin
			tiles <= nw'((n_size + BLOCK - 1) / BLOCK);
			last_sz <= ((n_size % BLOCK) == 0) ? rw'(BLOCK) : rw'(n_size % BLOCK);
		end
		if (sif.push)
		begin
			pend <= nxt;
			pend_lkey <= nxt_lkey;
		end
		if (go)
		begin
			run <= pend; // compute fields hold until comp_done.
			if (pend.mode != lu_pkg::mode_diag)
				prev_lkey <= pend_lkey;
		end
	end

endmodule

/* logic/xfer_gen.sv */
`timescale 1ns/1ps

module xfer_gen #(
	parameter int BLOCK = 8
) (
	input logic clk,
	input logic arst_n,
	input logic [lu_pkg::addr_width-1:0] base_addr,
	input logic [lu_pkg::n_width-1:0] n_size,
	step_if.xfer sif,
	output logic dtu_read_req,
	output logic dtu_write_req,
	output logic [lu_pkg::addr_width-1:0] dtu_mem_addr,
	output logic [lu_pkg::ram_width-1:0] dtu_ram_addr,
	output logic [lu_pkg::ram_width-1:0] dtu_size,
	output logic left_sel,
	input logic dtu_ack,
	input logic dtu_done
);

	localparam int aw = lu_pkg::addr_width;
	localparam int nw = lu_pkg::n_width;
	localparam int rw = lu_pkg::ram_width;

	lu_pkg::xfer_state_e state;
	lu_pkg::step_t q0;
	lu_pkg::step_t q1;
	lu_pkg::step_t rd_step;
	lu_pkg::step_t sel_step;
	logic [1:0] cnt; // unwritten steps held.
	logic [1:0] rcnt; // of those, already retired.
	logic rd_pend;
	logic need_left;
	logic loaded_q;
	logic [nw-1:0] pivot;
	logic is_wr;
	logic is_left;
	logic [aw-1:0] ld;
	logic [aw-1:0] addr_q;
	logic [rw-1:0] col_q;
	logic [rw-1:0] cols_q;
	logic [rw-1:0] size_q;
	logic sel_wr;
	logic sel_rd;
	logic sel_left;
	logic [nw-1:0] sel_row;
	logic [nw-1:0] sel_col;
	logic [rw-1:0] sel_cols;
	logic [rw-1:0] sel_size;
	logic [aw-1:0] sel_addr;
	logic in_req;
	logic last_col;
	logic burst_go;
	logic burst_end;
	logic pop;

	assign ld = aw'((n_size + BLOCK - 1) / BLOCK * BLOCK);

	// ====================
	// burst selection
	// ====================
	always_comb
	begin
		sel_wr = 1'b0;
		sel_rd = 1'b0;
		sel_left = 1'b0;
		sel_step = rd_step;
		if (rcnt != 2'd0)
		begin
			sel_wr = 1'b1; // write-back goes first.
			sel_step = q0;
		end
		else if (sif.push)
		begin
			sel_rd = 1'b1;
			sel_step = sif.step;
			sel_left = (sif.step.mode != lu_pkg::mode_diag);
		end
		else if (rd_pend)
		begin
			sel_rd = 1'b1;
			sel_left = need_left;
		end

		if (sel_left)
		begin
			sel_row = (sel_step.mode == lu_pkg::mode_update) ? sel_step.tile_row : pivot;
			sel_col = pivot;
			sel_cols = rw'(BLOCK); // pivot column is never the last one.
			sel_size = (sel_step.mode == lu_pkg::mode_update) ? sel_step.size_m : rw'(BLOCK);
		end
		else
		begin
			sel_row = sel_step.tile_row;
			sel_col = sel_step.tile_col;
			sel_cols = sel_step.size_n;
			sel_size = sel_step.size_m;
		end
		sel_addr = base_addr + aw'(sel_col) * aw'(BLOCK) * ld + aw'(sel_row) * aw'(BLOCK);
	end

	assign in_req = (state == lu_pkg::x_req) || (state == lu_pkg::x_wait_ack);
	assign last_col = (col_q + 1'b1 == cols_q);
	assign burst_go = ((state == lu_pkg::x_idle) || (state == lu_pkg::x_next)) && (sel_wr || sel_rd);
	assign burst_end = (state == lu_pkg::x_wait_done) && dtu_done;
	assign pop = burst_end && is_wr;

	assign dtu_read_req = in_req && !is_wr;
	assign dtu_write_req = in_req && is_wr;
	assign dtu_mem_addr = addr_q;
	assign dtu_ram_addr = col_q;
	assign dtu_size = size_q;
	assign left_sel = is_left && (in_req || (state == lu_pkg::x_wait_done));

	assign sif.loaded = loaded_q;
	assign sif.room = (cnt != 2'd2);
	assign sif.empty = (cnt == 2'd0);

	// ====================
	// control
	// ====================
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= lu_pkg::x_idle;
			cnt <= 2'd0;
			rcnt <= 2'd0;
			rd_pend <= 1'b0;
			need_left <= 1'b0;
			loaded_q <= 1'b0;
			is_wr <= 1'b0;
			is_left <= 1'b0;
		end
		else
		begin
			cnt <= cnt + {1'b0, sif.push} - {1'b0, pop};
			rcnt <= rcnt + {1'b0, sif.retire} - {1'b0, pop};
			if (sif.push)
			begin
				rd_pend <= 1'b1;
				need_left <= (sif.step.mode != lu_pkg::mode_diag);
				loaded_q <= 1'b0;
			end
			if (burst_end && !is_wr)
			begin
				if (is_left)
					need_left <= 1'b0;
				else
				begin
					rd_pend <= 1'b0;
					loaded_q <= 1'b1; // operands of the newest step are in.
				end
			end

			case (state)
				lu_pkg::x_idle, lu_pkg::x_next:
				begin
					if (burst_go)
					begin
						is_wr <= sel_wr;
						is_left <= sel_left;
						state <= lu_pkg::x_req;
					end
					else
						state <= lu_pkg::x_idle;
				end
				lu_pkg::x_req, lu_pkg::x_wait_ack:
				begin
					if (dtu_ack)
						state <= last_col ? lu_pkg::x_wait_done : lu_pkg::x_req;
					else
						state <= lu_pkg::x_wait_ack;
				end
				lu_pkg::x_wait_done:
				begin
					if (dtu_done)
						state <= lu_pkg::x_next;
				end
				default:
					state <= lu_pkg::x_idle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (burst_go)
		begin
			addr_q <= sel_addr;
			col_q <= '0;
			cols_q <= sel_cols;
			size_q <= sel_size;
		end
		else if (in_req && dtu_ack && !last_col)
		begin
			addr_q <= addr_q + ld; // next column, column-major.
			col_q <= col_q + 1'b1;
		end

		if (pop)
			q0 <= q1;
		if (sif.push)
		begin
			rd_step <= sif.step;
			if (sif.step.mode == lu_pkg::mode_diag)
				pivot <= sif.step.tile_row;
			if (cnt == {1'b0, pop})
				q0 <= sif.step;
			else
				q1 <= sif.step;
		end
	end

endmodule

/* logic/lu_marshal_top.sv */
`timescale 1ns/1ps

module lu_marshal_top #(
	parameter int BLOCK = 8,
	parameter int MAX_N = 64
) (
	input logic clk,
	input logic arst_n,
	input logic start,
	input logic [lu_pkg::n_width-1:0] n_size,
	input logic [lu_pkg::addr_width-1:0] base_addr,
	output logic done,
	// compute port.
	output logic comp_start,
	output lu_pkg::comp_mode_e mode,
	output logic [lu_pkg::ram_width-1:0] block_m,
	output logic [lu_pkg::ram_width-1:0] block_n,
	output logic cur_mem_sel,
	output logic left_mem_sel,
	input logic comp_done,
	// DTU port.
	output logic dtu_read_req,
	output logic dtu_write_req,
	output logic [lu_pkg::addr_width-1:0] dtu_mem_addr,
	output logic [lu_pkg::ram_width-1:0] dtu_ram_addr,
	output logic [lu_pkg::ram_width-1:0] dtu_size,
	output logic left_sel,
	input logic dtu_ack,
	input logic dtu_done
);

	step_if sif ();

	block_sched #(
		.BLOCK(BLOCK),
		.MAX_N(MAX_N)
	) u_sched (
		.clk(clk),
		.arst_n(arst_n),
		.start(start),
		.n_size(n_size),
		.done(done),
		.comp_start(comp_start),
		.mode(mode),
		.block_m(block_m),
		.block_n(block_n),
		.cur_mem_sel(cur_mem_sel),
		.left_mem_sel(left_mem_sel),
		.comp_done(comp_done),
		.sif(sif.sched)
	);

	xfer_gen #(
		.BLOCK(BLOCK)
	) u_xfer (
		.clk(clk),
		.arst_n(arst_n),
		.base_addr(base_addr),
		.n_size(n_size),
		.sif(sif.xfer),
		.dtu_read_req(dtu_read_req),
		.dtu_write_req(dtu_write_req),
		.dtu_mem_addr(dtu_mem_addr),
		.dtu_ram_addr(dtu_ram_addr),
		.dtu_size(dtu_size),
		.left_sel(left_sel),
		.dtu_ack(dtu_ack),
		.dtu_done(dtu_done)
	);

endmodule

/* test/lu_marshal_sva.sv */
`timescale 1ns/1ps

module lu_marshal_sva (
	input logic clk,
	input logic arst_n,
	input logic comp_start,
	input logic comp_done,
	input logic dtu_read_req,
	input logic dtu_write_req,
	input logic dtu_ack,
	input logic dtu_done
);

	logic comp_busy; // a compute is outstanding.
	logic rd_open; // read burst not yet closed by dtu_done.
	logic wr_open;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			comp_busy <= 1'b0;
		else if (comp_start)
			comp_busy <= 1'b1;
		else if (comp_done)
			comp_busy <= 1'b0;
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			rd_open <= 1'b0;
			wr_open <= 1'b0;
		end
		else if (dtu_done)
		begin
			rd_open <= 1'b0;
			wr_open <= 1'b0;
		end
		else
		begin
			if (dtu_read_req)
				rd_open <= 1'b1;
			if (dtu_write_req)
				wr_open <= 1'b1;
		end
	end

	req_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
		!(dtu_read_req && (dtu_write_req || wr_open)) && !(dtu_write_req && rd_open))
		else $error("read and write requests overlap within a burst");

	read_hold: assert property (@(posedge clk) disable iff (!arst_n)
		(dtu_read_req && !dtu_ack) |=> dtu_read_req)
		else $error("read request dropped before its ack");

	write_hold: assert property (@(posedge clk) disable iff (!arst_n)
		(dtu_write_req && !dtu_ack) |=> dtu_write_req)
		else $error("write request dropped before its ack");

	comp_single: assert property (@(posedge clk) disable iff (!arst_n)
		comp_start |-> !comp_busy)
		else $error("compute started while another one is outstanding");

endmodule

bind lu_marshal_top lu_marshal_sva sva0 (
	.clk(clk),
	.arst_n(arst_n),
	.comp_start(comp_start),
	.comp_done(comp_done),
	.dtu_read_req(dtu_read_req),
	.dtu_write_req(dtu_write_req),
	.dtu_ack(dtu_ack),
	.dtu_done(dtu_done)
);

/* test/lu_marshal_tb.sv */
`timescale 1ns/1ps

module lu_marshal_tb;

	localparam int nw = lu_pkg::n_width;
	localparam int aw = lu_pkg::addr_width;
	localparam int rw = lu_pkg::ram_width;
	localparam int blk = 8;
	localparam int rows = 4;

	typedef struct packed
	{
		int step;
		int wr;
		int left;
		int row;
		int col;
		int cols;
		int size;
	} burst_t;

	// ====================
	// stimulus table
	// ====================
	int tbl_n [rows] = '{8, 16, 20, 64};
	int tbl_base [rows] = '{0, 256, 4096, 1000};
	int tbl_steps [rows] = '{1, 5, 14, 204}; // sum of squares of the tile count.

	logic clk;
	logic arst_n;
	logic start;
	logic [nw-1:0] n_size;
	logic [aw-1:0] base_addr;
	logic done;
	logic comp_start;
	lu_pkg::comp_mode_e mode;
	logic [rw-1:0] block_m;
	logic [rw-1:0] block_n;
	logic cur_mem_sel;
	logic left_mem_sel;
	logic comp_done = 1'b0;
	logic dtu_read_req;
	logic dtu_write_req;
	logic [aw-1:0] dtu_mem_addr;
	logic [rw-1:0] dtu_ram_addr;
	logic [rw-1:0] dtu_size;
	logic left_sel;
	logic dtu_ack = 1'b0;
	logic dtu_done = 1'b0;

	int seed = 95261;
	int err_cnt = 0;
	int check_cnt = 0;
	int cycles = 0;
	int limit = 0;
	int comp_wait = 0;
	int ack_wait = 0;
	int done_wait = 0;
	logic after_ack = 1'b0;
	lu_pkg::step_t step_q [$];
	int lkey_q [$]; // left tile of each step, -1 for none.
	burst_t rd_q [$];
	burst_t wr_q [$];
	burst_t cur;
	int exp_steps;
	int comp_cnt;
	int comp_done_cnt;
	int rd_done; // steps whose operand reads are complete.
	int wr_done;
	int col_cnt;
	int run_base;
	int run_ld;
	int lkey_prev;
	logic lkey_valid = 1'b0;
	logic bank_q = 1'b0;
	logic lbank_q = 1'b0;
	logic done_q = 1'b0;
	logic done_cue = 1'b0;

	lu_marshal_top #(
		.BLOCK(blk),
		.MAX_N(64)
	) dut0 (
		.clk(clk),
		.arst_n(arst_n),
		.start(start),
		.n_size(n_size),
		.base_addr(base_addr),
		.done(done),
		.comp_start(comp_start),
		.mode(mode),
		.block_m(block_m),
		.block_n(block_n),
		.cur_mem_sel(cur_mem_sel),
		.left_mem_sel(left_mem_sel),
		.comp_done(comp_done),
		.dtu_read_req(dtu_read_req),
		.dtu_write_req(dtu_write_req),
		.dtu_mem_addr(dtu_mem_addr),
		.dtu_ram_addr(dtu_ram_addr),
		.dtu_size(dtu_size),
		.left_sel(left_sel),
		.dtu_ack(dtu_ack),
		.dtu_done(dtu_done)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic int rand_delay();
		return 1 + int'({$random(seed)} % 32'd4);
	endfunction

	function automatic int tile_size(int idx, int t, int lsz);
		return (idx == t - 1) ? lsz : blk; // last row and column are clamped.
	endfunction

	task automatic note_failure(string what);
		$display("ERROR at %0t: %s", $time, what);
		err_cnt = err_cnt + 1;
	endtask

	task automatic check_mode(string name, lu_pkg::comp_mode_e want, lu_pkg::comp_mode_e got);
		check_cnt = check_cnt + 1;
		if (want != got)
		begin
			$display("FAILED %0t %s expected %s actual %s", $time, name, want.name(), got.name());
			err_cnt = err_cnt + 1;
		end
	endtask

	task automatic check_field(string name, logic [rw-1:0] want, logic [rw-1:0] got);
		check_cnt = check_cnt + 1;
		if (want !== got)
		begin
			$display("FAILED %0t %s expected %0d actual %0d", $time, name, want, got);
			err_cnt = err_cnt + 1;
		end
	endtask

	task automatic check_addr(string name, logic [aw-1:0] want, logic [aw-1:0] got);
		check_cnt = check_cnt + 1;
		if (want !== got)
		begin
			$display("FAILED %0t %s expected %0h actual %0h", $time, name, want, got);
			err_cnt = err_cnt + 1;
		end
	endtask

	task automatic check_bit(string name, logic want, logic got);
		check_cnt = check_cnt + 1;
		if (want !== got)
		begin
			$display("FAILED %0t %s expected %b actual %b", $time, name, want, got);
			err_cnt = err_cnt + 1;
		end
	endtask

	// ====================
	// reference model
	// ====================
	task automatic add_step(lu_pkg::comp_mode_e md, int row, int col, int k, int t, int lsz);
		lu_pkg::step_t s;
		burst_t b;
		s.mode = md;
		s.tile_row = nw'(row);
		s.tile_col = nw'(col);
		s.size_m = rw'(tile_size(row, t, lsz));
		s.size_n = rw'(tile_size(col, t, lsz));
		s.last = (md == lu_pkg::mode_diag) && (k == t - 1);
		step_q.push_back(s);
		b.step = exp_steps;
		b.wr = 0;
		if (md != lu_pkg::mode_diag)
		begin
			b.left = 1;
			b.row = (md == lu_pkg::mode_update) ? row : k; // (i, k) or the pivot (k, k).
			b.col = k;
			b.size = tile_size(b.row, t, lsz);
			b.cols = tile_size(k, t, lsz);
			rd_q.push_back(b);
			lkey_q.push_back(b.row * 4096 + b.col);
		end
		else
			lkey_q.push_back(-1);
		b.left = 0;
		b.row = row;
		b.col = col;
		b.size = tile_size(row, t, lsz);
		b.cols = tile_size(col, t, lsz);
		rd_q.push_back(b);
		b.wr = 1;
		wr_q.push_back(b);
		exp_steps = exp_steps + 1;
	endtask

	task automatic build_expect(int n);
		int t;
		int lsz;
		t = (n + blk - 1) / blk;
		lsz = (n % blk == 0) ? blk : n % blk;
		for (int k = 0; k < t; k++)
		begin
			add_step(lu_pkg::mode_diag, k, k, k, t, lsz);
			for (int i = k + 1; i < t; i++)
				add_step(lu_pkg::mode_col, i, k, k, t, lsz);
			for (int j = k + 1; j < t; j++)
			begin
				add_step(lu_pkg::mode_row, k, j, k, t, lsz);
				for (int i = k + 1; i < t; i++)
					add_step(lu_pkg::mode_update, i, j, k, t, lsz);
			end
		end
	endtask

	// ====================
	// monitors
	// ====================
	task automatic check_compute();
		lu_pkg::step_t want;
		int key;
		if (step_q.size() == 0)
			note_failure("compute started with no step expected");
		else
		begin
			want = step_q.pop_front();
			key = lkey_q.pop_front();
			check_mode("mode", want.mode, mode);
			check_field("block_m", want.size_m, block_m);
			check_field("block_n", want.size_n, block_n);
			bank_q = ~bank_q; // every compute takes the other bank.
			check_bit("cur_mem_sel", bank_q, cur_mem_sel);
			if (key >= 0)
			begin
				if (!lkey_valid || key != lkey_prev)
					lbank_q = ~lbank_q; // a new left tile.
				lkey_prev = key;
				lkey_valid = 1'b1;
			end
			check_bit("left_mem_sel", lbank_q, left_mem_sel);
			if (rd_done <= comp_cnt)
				note_failure("compute started before its operand reads finished");
			comp_cnt = comp_cnt + 1;
		end
	endtask

	task automatic check_column();
		int a;
		if (col_cnt == 0)
		begin
			if (dtu_write_req && wr_q.size() != 0)
			begin
				cur = wr_q.pop_front();
				if (comp_done_cnt <= cur.step)
					note_failure("write-back started before its compute finished");
			end
			else if (dtu_read_req && rd_q.size() != 0)
			begin
				cur = rd_q.pop_front();
				if (cur.step >= 2 && wr_done < cur.step - 1)
					note_failure("reads started before the write-back two steps earlier");
			end
			else
				note_failure("DTU burst of an unexpected kind or with nothing expected");
		end
		a = run_base + (cur.col * blk + col_cnt) * run_ld + cur.row * blk;
		check_addr("dtu_mem_addr", aw'(a), dtu_mem_addr);
		check_field("dtu_ram_addr", rw'(col_cnt), dtu_ram_addr);
		check_field("dtu_size", rw'(cur.size), dtu_size);
		check_bit("left_sel", cur.left != 0, left_sel);
		col_cnt = col_cnt + 1;
		if (col_cnt == cur.cols)
		begin
			col_cnt = 0;
			if (cur.wr != 0)
				wr_done = wr_done + 1;
			else if (cur.left == 0)
				rd_done = cur.step + 1;
		end
	endtask

	always @(posedge clk)
	begin
		if (arst_n)
		begin
			if (comp_done)
				comp_done_cnt = comp_done_cnt + 1;
			if (comp_start)
				check_compute();
			if ((dtu_read_req || dtu_write_req) && dtu_ack)
				check_column();
			if (done && !done_q && (!done_cue || wr_q.size() != 0 || col_cnt != 0))
				note_failure("done did not rise one cycle after the final write-back");
			done_q = done;
			done_cue = dtu_done;
		end
	end

	// compute unit and DTU models share one random stream.
	always @(posedge clk)
	begin
		comp_done <= 1'b0;
		dtu_ack <= 1'b0;
		dtu_done <= 1'b0;
		if (comp_start)
			comp_wait = rand_delay();
		else if (comp_wait != 0)
		begin
			comp_wait = comp_wait - 1;
			if (comp_wait == 0)
				comp_done <= 1'b1;
		end
		if (dtu_ack)
			after_ack = 1'b1;
		else if (after_ack && !dtu_read_req && !dtu_write_req)
		begin
			after_ack = 1'b0; // request gone after an ack, burst is over.
			done_wait = rand_delay();
		end
		else if (done_wait != 0)
		begin
			done_wait = done_wait - 1;
			if (done_wait == 0)
				dtu_done <= 1'b1;
		end
		else if (dtu_read_req || dtu_write_req)
		begin
			after_ack = 1'b0;
			if (ack_wait == 0)
				ack_wait = rand_delay();
			ack_wait = ack_wait - 1;
			if (ack_wait == 0)
				dtu_ack <= 1'b1;
		end
	end

	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (limit != 0 && cycles >= limit)
		begin
			$display("timeout: the run did not finish within %0d cycles", limit);
			$display("Test failures found");
			$finish;
		end
	end

	// ====================
	// main sequence
	// ====================
	initial
	begin
		arst_n = 1'b0;
		start = 1'b0;
		n_size = '0;
		base_addr = '0;
		for (int r = 0; r < rows; r++)
			limit = limit + tbl_steps[r] * 200;
		repeat (16) @(posedge clk);
		arst_n <= 1'b1;
		@(posedge clk);
		for (int r = 0; r < rows; r++)
		begin
			exp_steps = 0;
			comp_cnt = 0;
			comp_done_cnt = 0;
			rd_done = 0;
			wr_done = 0;
			col_cnt = 0;
			lkey_valid = 1'b0;
			build_expect(tbl_n[r]);
			run_base = tbl_base[r];
			run_ld = ((tbl_n[r] + blk - 1) / blk) * blk;
			n_size <= nw'(tbl_n[r]);
			base_addr <= aw'(tbl_base[r]);
			start <= 1'b1;
			@(posedge clk);
			start <= 1'b0;
			do
				@(posedge clk);
			while (!done);
			if (step_q.size() + rd_q.size() + wr_q.size() != 0)
				note_failure("run finished with steps or bursts still expected");
			if (comp_cnt != tbl_steps[r])
				note_failure("number of compute steps differs from the table");
			repeat (4) @(posedge clk);
		end
		$display("checks: %0d errors: %0d", check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

/* filelist.f */
logic/lu_pkg.sv
logic/step_if.sv
logic/block_sched.sv
logic/xfer_gen.sv
logic/lu_marshal_top.sv
test/lu_marshal_sva.sv
test/lu_marshal_tb.sv

/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module lu_marshal_tb -f filelist.f -Mdir obj_dir -o sim

run: compile
	@out="$$(./obj_dir/sim)"; echo "$$out"; echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir
